// ==== design/mini_mcu_pkg.sv ====
// shared widths, instruction fields, opcode/ALU/state enums and the address map

`default_nettype none

package mini_mcu_pkg;

  // datapath and register file sizes
  localparam int XLEN   = 32;
  localparam int NREGS  = 8;
  localparam int REG_AW = 3;

  // instruction field positions and widths
  localparam int OPC_W   = 4;
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 25;
  localparam int RS1_LSB = 22;
  localparam int RS2_LSB = 19;
  localparam int IMM_W   = 16;

  // unlisted codes decode as halt
  typedef enum logic [OPC_W-1:0] {
    OP_ADDI = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLL  = 4'd6,
    OP_SRL  = 4'd7,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9,
    OP_BEQ  = 4'd10,
    OP_BNE  = 4'd11,
    OP_JMP  = 4'd12,
    OP_HALT = 4'd13
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_EQ
  } alu_op_e;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_IWAIT, S_EXEC, S_MEM, S_DWAIT, S_HALT
  } core_state_e;

  // data addresses from PERIPH_BASE upward go to the peripheral
  localparam logic [XLEN-1:0] PERIPH_BASE = 32'h0001_0000;
  localparam logic [XLEN-1:0] STATUS_OFS  = 32'h0000_0000;
  localparam logic [XLEN-1:0] EXIT_OFS    = 32'h0000_0004;

  // values written to the status register
  localparam logic [XLEN-1:0] PASS_CODE = 32'd123456789;
  localparam logic [XLEN-1:0] FAIL_CODE = 32'd1;

endpackage

`default_nettype wire

// ==== design/obi_if.sv ====
// request/grant/response-valid bus with master and slave modports

`default_nettype none

interface obi_if ();

  logic                          req;
  logic                          gnt;
  logic [mini_mcu_pkg::XLEN-1:0] addr;
  logic                          we;
  logic [mini_mcu_pkg::XLEN-1:0] wdata;
  logic [mini_mcu_pkg::XLEN-1:0] rdata;
  logic                          rvalid;

  // request side holds req/addr/we/wdata until gnt
  modport master (output req, addr, we, wdata, input gnt, rdata, rvalid);

  // rvalid follows each grant by one cycle
  modport slave (input req, addr, we, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

// ==== design/core_ctrl.sv ====
// core control FSM with program counter, instruction register and decoder

`default_nettype none

module core_ctrl #(
  parameter logic [mini_mcu_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            fetch_enable_i,
  obi_if.master                           instr_bus,
  obi_if.master                           data_bus,
  output logic [mini_mcu_pkg::REG_AW-1:0] rf_raddr_a_o,
  output logic [mini_mcu_pkg::REG_AW-1:0] rf_raddr_b_o,
  input  logic [mini_mcu_pkg::XLEN-1:0]   rf_rdata_a_i,
  input  logic [mini_mcu_pkg::XLEN-1:0]   rf_rdata_b_i,
  output logic                            rf_we_o,
  output logic [mini_mcu_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [mini_mcu_pkg::XLEN-1:0]   rf_wdata_o,
  output mini_mcu_pkg::alu_op_e           alu_op_o,
  output logic [mini_mcu_pkg::XLEN-1:0]   alu_a_o,
  output logic [mini_mcu_pkg::XLEN-1:0]   alu_b_o,
  input  logic [mini_mcu_pkg::XLEN-1:0]   alu_result_i,
  input  logic                            alu_eq_i
);

  localparam int XLEN  = mini_mcu_pkg::XLEN;
  localparam int IMM_W = mini_mcu_pkg::IMM_W;

  mini_mcu_pkg::core_state_e state;
  mini_mcu_pkg::opcode_e     opcode;
  logic [XLEN-1:0]           pc;
  logic [XLEN-1:0]           ir;
  logic [XLEN-1:0]           imm;
  logic [XLEN-1:0]           pc_plus4;
  logic [XLEN-1:0]           branch_target;
  logic [XLEN-1:0]           next_pc;
  logic                      use_imm;
  logic                      wb_alu;
  logic                      is_mem;
  logic                      is_halt;

  assign opcode = mini_mcu_pkg::opcode_e'(ir[mini_mcu_pkg::OPC_LSB +: mini_mcu_pkg::OPC_W]);
  assign imm    = {{(XLEN-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

  // instruction decode
  always_comb begin
    alu_op_o = mini_mcu_pkg::ALU_ADD;
    use_imm  = 1'b0;
    wb_alu   = 1'b0;
    is_mem   = 1'b0;
    is_halt  = 1'b0;
    case (opcode)
      mini_mcu_pkg::OP_ADDI: begin
        use_imm = 1'b1;
        wb_alu  = 1'b1;
      end
      mini_mcu_pkg::OP_ADD: wb_alu = 1'b1;
      mini_mcu_pkg::OP_SUB: begin
        alu_op_o = mini_mcu_pkg::ALU_SUB;
        wb_alu   = 1'b1;
      end
      mini_mcu_pkg::OP_AND: begin
        alu_op_o = mini_mcu_pkg::ALU_AND;
        wb_alu   = 1'b1;
      end
      mini_mcu_pkg::OP_OR: begin
        alu_op_o = mini_mcu_pkg::ALU_OR;
        wb_alu   = 1'b1;
      end
      mini_mcu_pkg::OP_XOR: begin
        alu_op_o = mini_mcu_pkg::ALU_XOR;
        wb_alu   = 1'b1;
      end
      mini_mcu_pkg::OP_SLL: begin
        alu_op_o = mini_mcu_pkg::ALU_SLL;
        wb_alu   = 1'b1;
      end
      mini_mcu_pkg::OP_SRL: begin
        alu_op_o = mini_mcu_pkg::ALU_SRL;
        wb_alu   = 1'b1;
      end
      // effective address rs1 + imm comes from the ALU adder
      mini_mcu_pkg::OP_LW, mini_mcu_pkg::OP_SW: begin
        use_imm = 1'b1;
        is_mem  = 1'b1;
      end
      mini_mcu_pkg::OP_BEQ, mini_mcu_pkg::OP_BNE: alu_op_o = mini_mcu_pkg::ALU_EQ;
      mini_mcu_pkg::OP_JMP: ;
      default: is_halt = 1'b1;
    endcase
  end

  // branch offsets and jump targets are counted in words
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc + (imm << 2);

  always_comb begin
    case (opcode)
      mini_mcu_pkg::OP_BEQ: next_pc = alu_eq_i ? branch_target : pc_plus4;
      mini_mcu_pkg::OP_BNE: next_pc = alu_eq_i ? pc_plus4 : branch_target;
      mini_mcu_pkg::OP_JMP: next_pc = imm << 2;
      default:              next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= mini_mcu_pkg::S_IDLE;
      pc    <= BOOT_ADDR;
    end else begin
      case (state)
        mini_mcu_pkg::S_IDLE:  if (fetch_enable_i) state <= mini_mcu_pkg::S_FETCH;
        mini_mcu_pkg::S_FETCH: if (instr_bus.gnt) state <= mini_mcu_pkg::S_IWAIT;
        mini_mcu_pkg::S_IWAIT: if (instr_bus.rvalid) state <= mini_mcu_pkg::S_EXEC;
        mini_mcu_pkg::S_EXEC: begin
          if (is_halt) begin
            state <= mini_mcu_pkg::S_HALT;
          end else begin
            pc    <= next_pc;
            state <= is_mem ? mini_mcu_pkg::S_MEM : mini_mcu_pkg::S_FETCH;
          end
        end
        mini_mcu_pkg::S_MEM:   if (data_bus.gnt) state <= mini_mcu_pkg::S_DWAIT;
        mini_mcu_pkg::S_DWAIT: if (data_bus.rvalid) state <= mini_mcu_pkg::S_FETCH;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == mini_mcu_pkg::S_IWAIT && instr_bus.rvalid) begin
      ir <= instr_bus.rdata;
    end
  end

  assign instr_bus.req   = (state == mini_mcu_pkg::S_FETCH);
  assign instr_bus.addr  = pc;
  assign instr_bus.we    = 1'b0;
  assign instr_bus.wdata = '0;

  // ir and register reads stay put during S_MEM, so the address is stable
  assign data_bus.req   = (state == mini_mcu_pkg::S_MEM);
  assign data_bus.addr  = alu_result_i;
  assign data_bus.we    = (opcode == mini_mcu_pkg::OP_SW);
  assign data_bus.wdata = rf_rdata_b_i;

  assign rf_raddr_a_o = ir[mini_mcu_pkg::RS1_LSB +: mini_mcu_pkg::REG_AW];
  assign rf_raddr_b_o = ir[mini_mcu_pkg::RS2_LSB +: mini_mcu_pkg::REG_AW];
  assign rf_waddr_o   = ir[mini_mcu_pkg::RD_LSB +: mini_mcu_pkg::REG_AW];
  assign alu_a_o      = rf_rdata_a_i;
  assign alu_b_o      = use_imm ? imm : rf_rdata_b_i;

  // write back from the ALU in S_EXEC or from the load response
  assign rf_we_o = (state == mini_mcu_pkg::S_EXEC && wb_alu) ||
                   (state == mini_mcu_pkg::S_DWAIT && data_bus.rvalid &&
                    opcode == mini_mcu_pkg::OP_LW);
  assign rf_wdata_o = (state == mini_mcu_pkg::S_DWAIT) ? data_bus.rdata : alu_result_i;

  // once halted no response may still arrive on either bus
  halt_quiet_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (state == mini_mcu_pkg::S_HALT) |-> !instr_bus.rvalid && !data_bus.rvalid);

  // a data request carries the address and data already settled in S_EXEC
  data_req_mem_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_bus.req |-> $stable(data_bus.addr) && $stable(data_bus.we) &&
      $stable(data_bus.wdata));

endmodule

`default_nettype wire

// ==== design/alu.sv ====
// combinational ALU with add, subtract, logic, shifts and equality compare

`default_nettype none

module alu (
  input  mini_mcu_pkg::alu_op_e          op_i,
  input  logic [mini_mcu_pkg::XLEN-1:0]  a_i,
  input  logic [mini_mcu_pkg::XLEN-1:0]  b_i,
  output logic [mini_mcu_pkg::XLEN-1:0]  result_o,
  output logic                           eq_o
);

  localparam int SHW = $clog2(mini_mcu_pkg::XLEN);

  logic [SHW-1:0] shamt;

  // shift amount is the low bits of b only
  assign shamt = b_i[SHW-1:0];
  assign eq_o  = (a_i == b_i);

  always_comb begin
    result_o = '0;
    case (op_i)
      mini_mcu_pkg::ALU_ADD: result_o = a_i + b_i;
      mini_mcu_pkg::ALU_SUB: result_o = a_i - b_i;
      mini_mcu_pkg::ALU_AND: result_o = a_i & b_i;
      mini_mcu_pkg::ALU_OR:  result_o = a_i | b_i;
      mini_mcu_pkg::ALU_XOR: result_o = a_i ^ b_i;
      mini_mcu_pkg::ALU_SLL: result_o = a_i << shamt;
      mini_mcu_pkg::ALU_SRL: result_o = a_i >> shamt;
      mini_mcu_pkg::ALU_EQ:  result_o = {{(mini_mcu_pkg::XLEN-1){1'b0}}, eq_o};
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// register file with two asynchronous read ports and one write port

`default_nettype none

module reg_file (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [mini_mcu_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [mini_mcu_pkg::REG_AW-1:0] raddr_b_i,
  output logic [mini_mcu_pkg::XLEN-1:0]   rdata_a_o,
  output logic [mini_mcu_pkg::XLEN-1:0]   rdata_b_o,
  input  logic                            we_i,
  input  logic [mini_mcu_pkg::REG_AW-1:0] waddr_i,
  input  logic [mini_mcu_pkg::XLEN-1:0]   wdata_i
);

  // r0 has no storage
  logic [mini_mcu_pkg::XLEN-1:0] regs [1:mini_mcu_pkg::NREGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < mini_mcu_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== design/mm_ram.sv ====
// dual-port word RAM with program-load port and peripheral window decoder

`default_nettype none

module mm_ram #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  obi_if.slave                          instr_bus,
  obi_if.slave                          data_bus,
  obi_if.master                         periph_bus,
  input  logic                          load_we_i,
  input  logic [$clog2(RAM_WORDS)-1:0]  load_addr_i,
  input  logic [mini_mcu_pkg::XLEN-1:0] load_wdata_i
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [mini_mcu_pkg::XLEN-1:0] mem [RAM_WORDS];
  logic [AW-1:0]                 instr_idx;
  logic [AW-1:0]                 data_idx;
  logic                          data_is_periph;
  logic                          ram_hit;
  logic                          instr_rvalid;
  logic                          ram_rvalid;
  logic                          periph_pend;
  logic [mini_mcu_pkg::XLEN-1:0] instr_rdata;
  logic [mini_mcu_pkg::XLEN-1:0] ram_rdata;

  // word index wraps modulo the RAM depth
  assign instr_idx      = instr_bus.addr[AW+1:2];
  assign data_idx       = data_bus.addr[AW+1:2];
  assign data_is_periph = (data_bus.addr >= mini_mcu_pkg::PERIPH_BASE);
  assign ram_hit        = data_bus.req && !data_is_periph;

  assign instr_bus.gnt = instr_bus.req;
  assign data_bus.gnt  = data_bus.req && (data_is_periph ? periph_bus.gnt : 1'b1);

  // peripheral sees the offset into its window
  assign periph_bus.req   = data_bus.req && data_is_periph;
  assign periph_bus.addr  = data_bus.addr - mini_mcu_pkg::PERIPH_BASE;
  assign periph_bus.we    = data_bus.we;
  assign periph_bus.wdata = data_bus.wdata;

  always_ff @(posedge clk_i) begin
    if (ram_hit && data_bus.we) begin
      mem[data_idx] <= data_bus.wdata;
    end
    if (load_we_i) begin
      mem[load_addr_i] <= load_wdata_i;
    end
    if (instr_bus.req) begin
      instr_rdata <= mem[instr_idx];
    end
    if (ram_hit && !data_bus.we) begin
      ram_rdata <= mem[data_idx];
    end
  end

  // periph_pend marks which source answers on data_bus next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      instr_rvalid <= 1'b0;
      ram_rvalid   <= 1'b0;
      periph_pend  <= 1'b0;
    end else begin
      instr_rvalid <= instr_bus.req && instr_bus.gnt;
      ram_rvalid   <= ram_hit && data_bus.gnt;
      periph_pend  <= periph_bus.req && periph_bus.gnt;
    end
  end

  assign instr_bus.rvalid = instr_rvalid;
  assign instr_bus.rdata  = instr_rdata;
  assign data_bus.rvalid  = ram_rvalid || periph_bus.rvalid;
  assign data_bus.rdata   = periph_pend ? periph_bus.rdata : ram_rdata;

  // programs are only loaded while the core is not fetching
  load_no_fetch_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(load_we_i && instr_bus.req));

  periph_rvalid_a: assert property (@(posedge clk_i) disable iff (rst_i)
    periph_bus.rvalid |-> $past(periph_bus.req && periph_bus.gnt));

endmodule

`default_nettype wire

// ==== design/exit_periph.sv ====
// test status flags, exit value register and exit-valid pulse

`default_nettype none

module exit_periph (
  input  logic                          clk_i,
  input  logic                          rst_i,
  obi_if.slave                          bus,
  output logic                          tests_passed_o,
  output logic                          tests_failed_o,
  output logic [mini_mcu_pkg::XLEN-1:0] exit_value_o,
  output logic                          exit_valid_o
);

  logic                          hit;
  logic                          sel_status;
  logic                          sel_exit;
  logic                          rvalid;
  logic [mini_mcu_pkg::XLEN-1:0] rdata;

  assign bus.gnt    = bus.req;
  assign hit        = bus.req && bus.gnt;
  assign sel_status = (bus.addr == mini_mcu_pkg::STATUS_OFS);
  assign sel_exit   = (bus.addr == mini_mcu_pkg::EXIT_OFS);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_value_o   <= '0;
      exit_valid_o   <= 1'b0;
      rvalid         <= 1'b0;
    end else begin
      rvalid       <= hit;
      exit_valid_o <= hit && bus.we && sel_exit;
      if (hit && bus.we && sel_exit) begin
        exit_value_o <= bus.wdata;
      end
      // status flags are sticky, unknown codes leave them alone
      if (hit && bus.we && sel_status) begin
        if (bus.wdata == mini_mcu_pkg::PASS_CODE) tests_passed_o <= 1'b1;
        if (bus.wdata == mini_mcu_pkg::FAIL_CODE) tests_failed_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit && !bus.we) begin
      rdata <= sel_exit ? exit_value_o : {30'b0, tests_failed_o, tests_passed_o};
    end
  end

  assign bus.rvalid = rvalid;
  assign bus.rdata  = rdata;

endmodule

`default_nettype wire

// ==== design/mini_mcu.sv ====
// top level with core control, ALU, register file, RAM, exit peripheral and buses

`default_nettype none

module mini_mcu #(
  parameter int unsigned                   RAM_WORDS = 1024,
  parameter logic [mini_mcu_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          fetch_enable_i,
  input  logic                          load_we_i,
  input  logic [$clog2(RAM_WORDS)-1:0]  load_addr_i,
  input  logic [mini_mcu_pkg::XLEN-1:0] load_wdata_i,
  output logic                          tests_passed_o,
  output logic                          tests_failed_o,
  output logic [mini_mcu_pkg::XLEN-1:0] exit_value_o,
  output logic                          exit_valid_o
);

  obi_if instr_bus ();
  obi_if data_bus ();
  obi_if periph_bus ();

  logic [mini_mcu_pkg::REG_AW-1:0] rf_raddr_a;
  logic [mini_mcu_pkg::REG_AW-1:0] rf_raddr_b;
  logic [mini_mcu_pkg::XLEN-1:0]   rf_rdata_a;
  logic [mini_mcu_pkg::XLEN-1:0]   rf_rdata_b;
  logic                            rf_we;
  logic [mini_mcu_pkg::REG_AW-1:0] rf_waddr;
  logic [mini_mcu_pkg::XLEN-1:0]   rf_wdata;
  mini_mcu_pkg::alu_op_e           alu_op;
  logic [mini_mcu_pkg::XLEN-1:0]   alu_a;
  logic [mini_mcu_pkg::XLEN-1:0]   alu_b;
  logic [mini_mcu_pkg::XLEN-1:0]   alu_result;
  logic                            alu_eq;

  core_ctrl #(
    .BOOT_ADDR(BOOT_ADDR)
  ) core_ctrl_inst (
    .clk_i, .rst_i, .fetch_enable_i,
    .instr_bus   (instr_bus.master),
    .data_bus    (data_bus.master),
    .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
    .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
    .rf_we_o     (rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .alu_op_o    (alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
    .alu_result_i(alu_result), .alu_eq_i(alu_eq)
  );

  alu alu_inst (
    .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result), .eq_o(alu_eq)
  );

  reg_file reg_file_inst (
    .clk_i, .rst_i,
    .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
    .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  mm_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) mm_ram_inst (
    .clk_i, .rst_i,
    .instr_bus (instr_bus.slave),
    .data_bus  (data_bus.slave),
    .periph_bus(periph_bus.master),
    .load_we_i, .load_addr_i, .load_wdata_i
  );

  exit_periph exit_periph_inst (
    .clk_i, .rst_i,
    .bus(periph_bus.slave),
    .tests_passed_o, .tests_failed_o, .exit_value_o, .exit_valid_o
  );

endmodule

`default_nettype wire

// ==== tests/mcu_checker.sv ====
// checker that compares exit value, exit pulses and status flags per case

`default_nettype none

module mcu_checker (
  input wire        clk_i,
  input wire        exit_valid_i,
  input wire [31:0] exit_value_i,
  input wire        passed_i,
  input wire        failed_i
);

  string       name;
  bit          active;
  bit          exp_pass;
  bit          exp_fail;
  logic [31:0] exp_exit;
  int          pulses;
  int          case_errors;
  int          errors;
  int          tests_run;
  int          tests_ok;

  initial begin
    active      = 1'b0;
    pulses      = 0;
    case_errors = 0;
    errors      = 0;
    tests_run   = 0;
    tests_ok    = 0;
  end

  // flags must be clear right after reset
  task automatic begin_case(input string n, input bit p, input bit f, input logic [31:0] ex);
    name        = n;
    exp_pass    = p;
    exp_fail    = f;
    exp_exit    = ex;
    pulses      = 0;
    case_errors = 0;
    active      = 1'b1;
    if (passed_i !== 1'b0 || failed_i !== 1'b0) begin
      $display("%s: status flags were not cleared by reset", name);
      case_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (active && exit_valid_i === 1'b1) begin
      if (pulses == 0 && exit_value_i !== exp_exit) begin
        $display("Mismatch at %0t: exit_value_o expected %h, got %h",
                 $time, exp_exit, exit_value_i);
        case_errors++;
      end
      pulses++;
    end
  end

  task automatic end_case();
    active = 1'b0;
    if (pulses == 0) begin
      $display("%s: exit_valid_o never arrived within the cycle budget", name);
      case_errors++;
    end else if (pulses != 1) begin
      $display("%s: expected one exit_valid_o pulse but saw %0d", name, pulses);
      case_errors++;
    end
    // the exit value holds after the pulse
    if (pulses > 0 && exit_value_i !== exp_exit) begin
      $display("Mismatch at %0t: exit_value_o expected %h, got %h",
               $time, exp_exit, exit_value_i);
      case_errors++;
    end
    if (passed_i !== exp_pass) begin
      $display("Mismatch at %0t: tests_passed_o expected %b, got %b", $time, exp_pass, passed_i);
      case_errors++;
    end
    if (failed_i !== exp_fail) begin
      $display("Mismatch at %0t: tests_failed_o expected %b, got %b", $time, exp_fail, failed_i);
      case_errors++;
    end
    tests_run++;
    if (case_errors == 0) begin
      tests_ok++;
      $display("test %s ok", name);
    end else begin
      $display("test %s failed with %0d errors", name, case_errors);
    end
    errors += case_errors;
  endtask

  task automatic summary();
    $display("tests %0d, ok %0d, failed %0d, errors %0d",
             tests_run, tests_ok, tests_run - tests_ok, errors);
  endtask

endmodule

`default_nettype wire

// ==== tests/tb_mini_mcu.sv ====
// testbench top with clock, reset, case file reader, program loader, sequencing and timeout

`default_nettype none

module tb_mini_mcu;

  localparam int RAM_WORDS = 1024;
  localparam int AW        = $clog2(RAM_WORDS);

  logic                          clk_i;
  logic                          rst_i;
  logic                          fetch_enable_i;
  logic                          load_we_i;
  logic [AW-1:0]                 load_addr_i;
  logic [mini_mcu_pkg::XLEN-1:0] load_wdata_i;
  logic                          tests_passed_o;
  logic                          tests_failed_o;
  logic [mini_mcu_pkg::XLEN-1:0] exit_value_o;
  logic                          exit_valid_o;

  // cases as read from the file
  string       case_names[$];
  int          case_nwords[$];
  logic [31:0] case_words[$];
  string       case_status[$];
  logic [31:0] case_exit[$];
  int          case_budget[$];

  int          cycles;
  int          cycle_limit;

  mini_mcu #(
    .RAM_WORDS(RAM_WORDS),
    .BOOT_ADDR('0)
  ) mini_mcu_inst (
    .clk_i, .rst_i, .fetch_enable_i,
    .load_we_i, .load_addr_i, .load_wdata_i,
    .tests_passed_o, .tests_failed_o, .exit_value_o, .exit_valid_o
  );

  mcu_checker mcu_checker (
    .clk_i, .exit_valid_i(exit_valid_o), .exit_value_i(exit_value_o),
    .passed_i(tests_passed_o), .failed_i(tests_failed_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles, the cases did not finish in time", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // header line per case, then the program words in hex
  task automatic read_cases(output bit ok);
    int          fd;
    int          n;
    int          nw;
    int          budget;
    string       line;
    string       name;
    string       status;
    logic [31:0] ex;
    logic [31:0] w;
    ok = 1'b0;
    fd = $fopen("tests/mcu_cases.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %d %s %h %d", name, nw, status, ex, budget);
      if (n != 5) begin
        continue;
      end
      for (int i = 0; i < nw; i++) begin
        n = $fscanf(fd, " %h", w);
        case_words.push_back(w);
      end
      case_names.push_back(name);
      case_nwords.push_back(nw);
      case_status.push_back(status);
      case_exit.push_back(ex);
      case_budget.push_back(budget);
    end
    $fclose(fd);
    ok = (case_names.size() > 0);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i          <= 1'b1;
    fetch_enable_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  task automatic load_program(input int first, input int nw);
    for (int i = 0; i < nw; i++) begin
      @(posedge clk_i);
      load_we_i    <= 1'b1;
      load_addr_i  <= AW'(i);
      load_wdata_i <= case_words[first + i];
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic run_case(input int idx, input int first);
    int gap;
    int c;
    bit seen;
    apply_reset();
    load_program(first, case_nwords[idx]);
    // checker state changes away from the sampling edge
    @(negedge clk_i);
    mcu_checker.begin_case(case_names[idx], case_status[idx] == "pass",
                           case_status[idx] == "fail", case_exit[idx]);
    gap = int'($urandom % 8);
    repeat (gap + 1) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    c    = 0;
    seen = 1'b0;
    while (!seen && c < case_budget[idx]) begin
      @(posedge clk_i);
      seen = exit_valid_o;
      c++;
    end
    // keep watching so late pulses after halt are caught
    while (c < case_budget[idx]) begin
      @(posedge clk_i);
      c++;
    end
    fetch_enable_i <= 1'b0;
    @(negedge clk_i);
    mcu_checker.end_case();
  endtask

  initial begin
    bit ok;
    int first;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    load_we_i      = 1'b0;
    load_addr_i    = '0;
    load_wdata_i   = '0;
    cycles         = 0;
    cycle_limit    = 0;
    void'($urandom(32'h19de5305));
    read_cases(ok);
    if (!ok) begin
      $display("could not read any case from tests/mcu_cases.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      cycle_limit = 5;
      foreach (case_budget[i]) cycle_limit += case_budget[i] + 10 * case_nwords[i];
      first = 0;
      foreach (case_names[i]) begin
        run_case(i, first);
        first += case_nwords[i];
      end
      mcu_checker.summary();
      if (mcu_checker.errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/mcu_cases.txt ====
# header: name word_count status(pass/fail/none) exit_value_hex cycle_budget
# then word_count program words in hex
alu 17 none 00094000 150
0E000001 0C000010 6FF00000 02000064 0400FFFD 16500000 26D00000 080000F0
3AE00000 4B480000 5B600000 6B700000 7B480000 00000037 1B400000 91E80004
D0000000
mem 13 none 12340555 150
0E000001 0C000010 6FF00000 02001234 04000555 90080100 90101104 86000100
88000104 66F00000 4AE00000 91E80004 D0000000
loop 18 none 0005000F 250
0E000001 0C000010 6FF00000 02000005 04000000 06000000 14880000 06C00001
0240FFFF B040FFFD A0000002 04800064 66F00000 4AD00000 C0000010 91F00004
91E80004 D0000000
pass 10 pass 075BCD15 120
0E000001 0C000010 6FF00000 91F00000 0200075C 62700000 0240CD15 91C80000
91C80004 D0000000
fail 8 fail 0000002A 100
0E000001 0C000010 6FF00000 02000001 91C80000 0400002A 91D00004 D0000000
none 7 none 00000007 100
0E000001 0C000010 6FF00000 02000007 91C80000 91C80004 D0000000

// ==== tb.f ====
design/mini_mcu_pkg.sv
design/obi_if.sv
design/core_ctrl.sv
design/alu.sv
design/reg_file.sv
design/mm_ram.sv
design/exit_periph.sv
design/mini_mcu.sv
tests/mcu_checker.sv
tests/tb_mini_mcu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= tb.f
SEED      ?= 0
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
